// ==== Makefile ====
SIM = obj_dir/Vtb_rvv_coproc
LOG = sim.log

.PHONY: all run lint clean

all: run

$(SIM): verilog.f $(wildcard design/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_rvv_coproc -o Vtb_rvv_coproc

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module rvv_coproc

clean:
	rm -rf obj_dir $(LOG)

// ==== design/rvv_cfg_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_cfg_unit (
	input  wire                clk,
	input  wire                resetn,
	input  wire                commit_i,
	input  wire [1:0]          cfg_kind_i,
	input  wire [1:0]          avl_src_i,
	input  wire [31:0]         insn_i,
	input  wire [31:0]         rs1_i,
	input  wire [31:0]         rs2_i,
	output logic [31:0]        vl_o,
	output rvv_pkg::sew_t      sew_o,
	output logic [2:0]         lmul_o,
	output logic               vill_o
);
	logic [31:0] vtype_q;
	logic [31:0] vl_q;
	logic [31:0] vtype_new;
	logic [31:0] vlmax_base; // elements per register
	logic [31:0] vlmax;
	logic [31:0] avl;
	logic        ill;

	always_comb begin
		if (cfg_kind_i == rvv_pkg::CFG_VSETVL)
			vtype_new = rs2_i;
		else
			vtype_new = {24'd0, insn_i[27:20]}; // vma, vta, vsew, vlmul
		vlmax_base = rvv_pkg::VLEN >> (vtype_new[5:3] + 3);
		case (vtype_new[2:0])
			3'd5: vlmax = vlmax_base >> 3; // lmul 1/8
			3'd6: vlmax = vlmax_base >> 2;
			3'd7: vlmax = vlmax_base >> 1;
			default: vlmax = vlmax_base << vtype_new[2:0];
		endcase
		ill = vtype_new[31] || vtype_new[30:8] != 23'd0 || vtype_new[2:0] == 3'd4
			|| vtype_new[5:3] > rvv_pkg::SEW_32 || vlmax == 32'd0;
		case (avl_src_i)
			rvv_pkg::AVL_RS1: avl = rs1_i;
			rvv_pkg::AVL_IMM: avl = {27'd0, insn_i[19:15]};
			rvv_pkg::AVL_MAX: avl = 32'hffff_ffff;
			default: avl = vl_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= rvv_pkg::VTYPE_ILL;
			vl_q    <= 32'd0;
		end else if (commit_i) begin
			if (ill) begin
				vtype_q <= rvv_pkg::VTYPE_ILL;
				vl_q    <= 32'd0;
			end else begin
				vtype_q <= vtype_new;
				vl_q    <= (avl < vlmax) ? avl : vlmax;
			end
		end
	end

	assign vl_o   = vl_q;
	assign sew_o  = vtype_q[5:3];
	assign lmul_o = vtype_q[2:0];
	assign vill_o = vtype_q[31];
endmodule

`default_nettype wire

// ==== design/rvv_coproc.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_coproc (
	input  wire         clk,
	input  wire         resetn,
	input  wire         pcpi_valid_i,
	input  wire [31:0]  pcpi_insn_i,
	input  wire [31:0]  pcpi_rs1_i,
	input  wire [31:0]  pcpi_rs2_i,
	output logic        pcpi_wr_o,
	output logic [31:0] pcpi_rd_o,
	output logic        pcpi_wait_o,
	output logic        pcpi_ready_o,
	output logic        pcpi_is_rvv_o,
	input  wire [31:0]  mem_rdata_i,
	input  wire         mem_done_i,
	output logic        mem_valid_o,
	output logic        mem_op_o,
	output logic        mem_first_o,
	output logic        mem_we_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0]  mem_strb_o
);
	rvv_pkg::insn_kind_t kind;
	rvv_pkg::vaddr_t     vd;
	rvv_pkg::vaddr_t     reg_off;
	rvv_pkg::vaddr_t     vreg_addr;
	rvv_pkg::sew_t       eew;
	rvv_pkg::sew_t       sew;
	rvv_pkg::byte_idx_t  byte_idx;
	rvv_pkg::vreg_t      vreg_rdata;
	rvv_pkg::vreg_t      vreg_wdata;
	rvv_pkg::vstrb_t     vreg_strb;
	logic [1:0]  cfg_kind;
	logic [1:0]  avl_src;
	logic [31:0] vl;
	logic [31:0] elem;
	logic        vill;
	logic        cfg_commit;
	logic        step;
	logic        clear;
	logic        last;
	logic        empty;
	logic        vreg_we;
	logic        is_store;

	assign is_store  = kind == rvv_pkg::KIND_STORE;
	assign mem_we_o  = is_store;
	assign pcpi_rd_o = vl;
	assign vreg_addr = vd + reg_off; // register group walk

	rvv_insn_decode u_decode (
		.insn_i     (pcpi_insn_i),
		.vill_i     (vill),
		.sew_i      (sew),
		.kind_o     (kind),
		.is_rvv_o   (pcpi_is_rvv_o),
		.vd_o       (vd),
		.cfg_kind_o (cfg_kind),
		.avl_src_o  (avl_src),
		.eew_o      (eew)
	);

	rvv_cfg_unit u_cfg (
		.clk        (clk),
		.resetn     (resetn),
		.commit_i   (cfg_commit),
		.cfg_kind_i (cfg_kind),
		.avl_src_i  (avl_src),
		.insn_i     (pcpi_insn_i),
		.rs1_i      (pcpi_rs1_i),
		.rs2_i      (pcpi_rs2_i),
		.vl_o       (vl),
		.sew_o      (sew),
		.lmul_o     (),
		.vill_o     (vill)
	);

	rvv_ctrl_fsm u_fsm (
		.clk          (clk),
		.resetn       (resetn),
		.valid_i      (pcpi_valid_i),
		.kind_i       (kind),
		.mem_done_i   (mem_done_i),
		.last_i       (last),
		.empty_i      (empty),
		.ready_o      (pcpi_ready_o),
		.wr_o         (pcpi_wr_o),
		.wait_o       (pcpi_wait_o),
		.cfg_commit_o (cfg_commit),
		.mem_valid_o  (mem_valid_o),
		.mem_first_o  (mem_first_o),
		.mem_op_o     (mem_op_o),
		.step_o       (step),
		.clear_o      (clear),
		.vreg_we_o    (vreg_we)
	);

	rvv_elem_counter u_counter (
		.clk       (clk),
		.resetn    (resetn),
		.step_i    (step),
		.clear_i   (clear),
		.vl_i      (vl),
		.sew_i     (eew),
		.elem_o    (elem),
		.reg_off_o (reg_off),
		.byte_o    (byte_idx),
		.last_o    (last),
		.empty_o   (empty)
	);

	rvv_mem_lane u_lane (
		.base_i       (pcpi_rs1_i),
		.elem_i       (elem),
		.byte_i       (byte_idx),
		.sew_i        (eew),
		.is_store_i   (is_store),
		.vreg_rdata_i (vreg_rdata),
		.mem_rdata_i  (mem_rdata_i),
		.addr_o       (mem_addr_o),
		.strb_o       (mem_strb_o),
		.wdata_o      (mem_wdata_o),
		.vreg_wdata_o (vreg_wdata),
		.vreg_strb_o  (vreg_strb)
	);

	rvv_vregs u_vregs (
		.clk     (clk),
		.we_i    (vreg_we),
		.waddr_i (vreg_addr),
		.wstrb_i (vreg_strb),
		.wdata_i (vreg_wdata),
		.raddr_i (vreg_addr),
		.rdata_o (vreg_rdata)
	);
endmodule

`default_nettype wire

// ==== design/rvv_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_ctrl_fsm (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       valid_i,
	input  wire rvv_pkg::insn_kind_t  kind_i,
	input  wire                       mem_done_i,
	input  wire                       last_i,
	input  wire                       empty_i,
	output logic                      ready_o,
	output logic                      wr_o,
	output logic                      wait_o,
	output logic                      cfg_commit_o,
	output logic                      mem_valid_o,
	output logic                      mem_first_o,
	output logic                      mem_op_o,
	output logic                      step_o,
	output logic                      clear_o,
	output logic                      vreg_we_o
);
	rvv_pkg::fsm_state_t state_q;
	rvv_pkg::fsm_state_t state_d;
	logic hold_q;  // set after finish until the core drops valid
	logic first_q;
	logic is_mem;
	logic start;

	assign is_mem = kind_i == rvv_pkg::KIND_LOAD || kind_i == rvv_pkg::KIND_STORE;
	assign start  = state_q == rvv_pkg::ST_IDLE && valid_i && !hold_q
		&& kind_i != rvv_pkg::KIND_NONE;

	always_comb begin
		state_d = state_q;
		case (state_q)
			rvv_pkg::ST_IDLE:
				if (start)
					state_d = (is_mem && !empty_i) ? rvv_pkg::ST_WAIT_DONE : rvv_pkg::ST_FINISH;
			rvv_pkg::ST_ISSUE:
				state_d = rvv_pkg::ST_WAIT_DONE; // one idle cycle between requests
			rvv_pkg::ST_WAIT_DONE:
				if (mem_done_i)
					state_d = last_i ? rvv_pkg::ST_FINISH : rvv_pkg::ST_ISSUE;
			default:
				state_d = rvv_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= rvv_pkg::ST_IDLE;
			hold_q  <= 1'b0;
			first_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == rvv_pkg::ST_FINISH)
				hold_q <= 1'b1;
			else if (!valid_i)
				hold_q <= 1'b0;
			if (start && is_mem && !empty_i)
				first_q <= 1'b1;
			else if (mem_done_i)
				first_q <= 1'b0;
		end
	end

	assign mem_valid_o  = state_q == rvv_pkg::ST_WAIT_DONE;
	assign mem_first_o  = first_q;
	assign mem_op_o     = state_q == rvv_pkg::ST_ISSUE || mem_valid_o;
	assign wait_o       = mem_op_o;
	assign ready_o      = state_q == rvv_pkg::ST_FINISH;
	assign wr_o         = ready_o && kind_i == rvv_pkg::KIND_CFG; // only config returns vl
	assign clear_o      = ready_o;
	assign cfg_commit_o = start && kind_i == rvv_pkg::KIND_CFG;
	assign step_o       = mem_valid_o && mem_done_i && !last_i;
	assign vreg_we_o    = mem_valid_o && mem_done_i && kind_i == rvv_pkg::KIND_LOAD;
endmodule

`default_nettype wire

// ==== design/rvv_elem_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_elem_counter (
	input  wire                  clk,
	input  wire                  resetn,
	input  wire                  step_i,
	input  wire                  clear_i,
	input  wire [31:0]           vl_i,
	input  wire rvv_pkg::sew_t   sew_i,
	output logic [31:0]          elem_o,
	output rvv_pkg::vaddr_t      reg_off_o,
	output rvv_pkg::byte_idx_t   byte_o,
	output logic                 last_o,
	output logic                 empty_o
);
	logic [4:0] byte_next; // bit 4 is the wrap into the next register

	assign byte_next = {1'b0, byte_o} + (5'd1 << sew_i);

	always_ff @(posedge clk) begin
		if (!resetn || clear_i) begin
			elem_o    <= 32'd0;
			reg_off_o <= 5'd0;
			byte_o    <= 4'd0;
		end else if (step_i) begin
			elem_o <= elem_o + 32'd1;
			byte_o <= byte_next[3:0];
			if (byte_next[4])
				reg_off_o <= reg_off_o + 5'd1;
		end
	end

	assign last_o  = elem_o == vl_i - 32'd1;
	assign empty_o = vl_i == 32'd0;
endmodule

`default_nettype wire

// ==== design/rvv_insn_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_insn_decode (
	input  wire [31:0]               insn_i,
	input  wire                      vill_i,
	input  wire rvv_pkg::sew_t       sew_i,
	output rvv_pkg::insn_kind_t      kind_o,
	output logic                     is_rvv_o,
	output rvv_pkg::vaddr_t          vd_o,
	output logic [1:0]               cfg_kind_o,
	output logic [1:0]               avl_src_o,
	output rvv_pkg::sew_t            eew_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       is_cfg;
	logic       is_mem;
	logic       width_ok;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];
	assign vd_o   = insn_i[11:7]; // vs3 on stores

	always_comb begin
		width_ok = 1'b1;
		eew_o    = rvv_pkg::SEW_8;
		case (funct3)
			3'b000: eew_o = rvv_pkg::SEW_8;
			3'b101: eew_o = rvv_pkg::SEW_16;
			3'b110: eew_o = rvv_pkg::SEW_32;
			default: width_ok = 1'b0;
		endcase
	end

	// unit-stride only: nf, mew and mop all zero
	assign is_mem = (opcode == rvv_pkg::OPC_LOAD_FP || opcode == rvv_pkg::OPC_STORE_FP)
		&& insn_i[31:26] == 6'd0 && width_ok;

	always_comb begin
		is_cfg     = 1'b0;
		cfg_kind_o = rvv_pkg::CFG_VSETVLI;
		if (opcode == rvv_pkg::OPC_VCFG && funct3 == rvv_pkg::FUNCT3_CFG) begin
			if (!insn_i[31]) begin
				is_cfg = 1'b1;
			end else if (insn_i[30]) begin
				is_cfg     = 1'b1;
				cfg_kind_o = rvv_pkg::CFG_VSETIVLI;
			end else if (insn_i[29:25] == 5'd0) begin
				is_cfg     = 1'b1;
				cfg_kind_o = rvv_pkg::CFG_VSETVL;
			end
		end
	end

	always_comb begin
		if (cfg_kind_o == rvv_pkg::CFG_VSETIVLI)
			avl_src_o = rvv_pkg::AVL_IMM;
		else if (insn_i[19:15] != 5'd0)
			avl_src_o = rvv_pkg::AVL_RS1;
		else if (insn_i[11:7] != 5'd0)
			avl_src_o = rvv_pkg::AVL_MAX;
		else
			avl_src_o = rvv_pkg::AVL_KEEP;
	end

	// memory ops need a legal vtype, and EEW must match SEW so EMUL equals LMUL
	always_comb begin
		kind_o = rvv_pkg::KIND_NONE;
		if (is_cfg)
			kind_o = rvv_pkg::KIND_CFG;
		else if (is_mem && !vill_i && eew_o == sew_i)
			kind_o = insn_i[5] ? rvv_pkg::KIND_STORE : rvv_pkg::KIND_LOAD;
	end

	assign is_rvv_o = kind_o != rvv_pkg::KIND_NONE;
endmodule

`default_nettype wire

// ==== design/rvv_mem_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_mem_lane (
	input  wire [31:0]               base_i,
	input  wire [31:0]               elem_i,
	input  wire rvv_pkg::byte_idx_t  byte_i,
	input  wire rvv_pkg::sew_t       sew_i,
	input  wire                      is_store_i,
	input  wire rvv_pkg::vreg_t      vreg_rdata_i,
	input  wire [31:0]               mem_rdata_i,
	output logic [31:0]              addr_o,
	output logic [3:0]               strb_o,
	output logic [31:0]              wdata_o,
	output rvv_pkg::vreg_t           vreg_wdata_o,
	output rvv_pkg::vstrb_t          vreg_strb_o
);
	logic [3:0]  elem_strb; // element bytes at lane 0
	logic [31:0] elem_mask;
	logic [1:0]  offs;
	logic [31:0] reg_word;
	logic [31:0] load_elem;

	always_comb begin
		case (sew_i)
			rvv_pkg::SEW_8:  elem_strb = 4'b0001;
			rvv_pkg::SEW_16: elem_strb = 4'b0011;
			default:         elem_strb = 4'b1111;
		endcase
	end

	assign elem_mask = {{8{elem_strb[3]}}, {8{elem_strb[2]}}, {8{elem_strb[1]}}, {8{elem_strb[0]}}};

	// aligned elements never cross a word
	assign addr_o = base_i + (elem_i << sew_i);
	assign offs   = addr_o[1:0];
	assign strb_o = elem_strb << offs;

	// bytes of the register from byte_i upward
	assign reg_word = 32'(vreg_rdata_i >> {byte_i, 3'b000});
	assign wdata_o  = is_store_i ? (reg_word & elem_mask) << {offs, 3'b000} : 32'd0;

	assign load_elem    = (mem_rdata_i >> {offs, 3'b000}) & elem_mask;
	assign vreg_wdata_o = rvv_pkg::vreg_t'(load_elem) << {byte_i, 3'b000};
	assign vreg_strb_o  = is_store_i ? '0 : rvv_pkg::vstrb_t'(elem_strb) << byte_i;
endmodule

`default_nettype wire

// ==== design/rvv_pkg.sv ====
`default_nettype none

package rvv_pkg;
	localparam integer VLEN  = 128;
	localparam integer VLENB = VLEN / 8;
	localparam integer NREGS = 32;

	// major opcodes, config minor code
	localparam logic [6:0] OPC_VCFG     = 7'b1010111;
	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
	localparam logic [2:0] FUNCT3_CFG   = 3'b111;

	localparam logic [31:0] VTYPE_ILL = 32'h8000_0000; // vill alone

	typedef logic [VLEN-1:0]  vreg_t;
	typedef logic [VLENB-1:0] vstrb_t;
	typedef logic [4:0]       vaddr_t;
	typedef logic [3:0]       byte_idx_t;
	typedef logic [2:0]       sew_t;

	localparam sew_t SEW_8  = 3'd0;
	localparam sew_t SEW_16 = 3'd1;
	localparam sew_t SEW_32 = 3'd2;

	// config instruction flavour
	localparam logic [1:0] CFG_VSETVLI  = 2'd0;
	localparam logic [1:0] CFG_VSETIVLI = 2'd1;
	localparam logic [1:0] CFG_VSETVL   = 2'd2;

	// where avl comes from
	localparam logic [1:0] AVL_RS1  = 2'd0;
	localparam logic [1:0] AVL_IMM  = 2'd1;
	localparam logic [1:0] AVL_MAX  = 2'd2; // rs1 is x0, rd is not
	localparam logic [1:0] AVL_KEEP = 2'd3; // both x0

	typedef enum logic [1:0] {KIND_NONE, KIND_CFG, KIND_LOAD, KIND_STORE} insn_kind_t;
	typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT_DONE, ST_FINISH} fsm_state_t;
endpackage

`default_nettype wire

// ==== design/rvv_vregs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_vregs (
	input  wire                   clk,
	input  wire                   we_i,
	input  wire rvv_pkg::vaddr_t  waddr_i,
	input  wire rvv_pkg::vstrb_t  wstrb_i,
	input  wire rvv_pkg::vreg_t   wdata_i,
	input  wire rvv_pkg::vaddr_t  raddr_i,
	output rvv_pkg::vreg_t        rdata_o
);
	rvv_pkg::vreg_t regs [rvv_pkg::NREGS];

	initial begin
		for (int i = 0; i < rvv_pkg::NREGS; i++)
			regs[i] = '0;
	end

	always @(posedge clk) begin
		if (we_i) begin
			for (int b = 0; b < rvv_pkg::VLENB; b++)
				if (wstrb_i[b])
					regs[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
		end
	end

	assign rdata_o = regs[raddr_i]; // async read
endmodule

`default_nettype wire

// ==== test/tb_rvv_coproc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_coproc;
	localparam int MEM_BYTES  = 1024;
	localparam int MAX_CYCLES = 4000; // longest run is about 1000 cycles
	localparam int SRC_ADDR   = 'h040;
	localparam int DST_ADDR   = 'h200;
	localparam logic [31:0] SEED = 32'hc09e0da0;

	logic        clk = 1'b0;
	logic        resetn;
	logic        pcpi_valid;
	logic [31:0] pcpi_insn;
	logic [31:0] pcpi_rs1;
	logic [31:0] pcpi_rs2;
	logic [31:0] mem_rdata;
	logic        mem_done;
	logic        pcpi_wr_o;
	logic [31:0] pcpi_rd_o;
	logic        pcpi_wait_o;
	logic        pcpi_ready_o;
	logic        pcpi_is_rvv_o;
	logic        mem_valid_o;
	logic        mem_op_o;
	logic        mem_first_o;
	logic        mem_we_o;
	logic [31:0] mem_addr_o;
	logic [31:0] mem_wdata_o;
	logic [3:0]  mem_strb_o;

	logic [7:0] mem [MEM_BYTES];
	string test_name;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_errs = 0;
	int cycle_count;

	// what the memory model expects of the next requests
	int   exp_base;
	int   exp_size;
	logic exp_store;
	int   req_seen;
	int   req_done;

	rvv_coproc dut (
		.clk           (clk),
		.resetn        (resetn),
		.pcpi_valid_i  (pcpi_valid),
		.pcpi_insn_i   (pcpi_insn),
		.pcpi_rs1_i    (pcpi_rs1),
		.pcpi_rs2_i    (pcpi_rs2),
		.pcpi_wr_o     (pcpi_wr_o),
		.pcpi_rd_o     (pcpi_rd_o),
		.pcpi_wait_o   (pcpi_wait_o),
		.pcpi_ready_o  (pcpi_ready_o),
		.pcpi_is_rvv_o (pcpi_is_rvv_o),
		.mem_rdata_i   (mem_rdata),
		.mem_done_i    (mem_done),
		.mem_valid_o   (mem_valid_o),
		.mem_op_o      (mem_op_o),
		.mem_first_o   (mem_first_o),
		.mem_we_o      (mem_we_o),
		.mem_addr_o    (mem_addr_o),
		.mem_wdata_o   (mem_wdata_o),
		.mem_strb_o    (mem_strb_o)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_errs) begin
			$display("test %s: ok", test_name);
		end else begin
			failed_tests++;
			$display("test %s: FAILED, %0d errors", test_name, errors - test_errs);
		end
	endtask

	// vl rule: VLEN / SEW, scaled by LMUL or by 1/2, 1/4, 1/8
	function automatic int vlmax_of(input int sew, input int lmul);
		int base;
		base = rvv_pkg::VLEN / (8 << sew);
		case (lmul)
			5: return base / 8;
			6: return base / 4;
			7: return base / 2;
			default: return base << lmul;
		endcase
	endfunction

	function automatic logic [31:0] expected_vl(input logic [31:0] avl, input int sew, input int lmul);
		int max;
		if (sew > 2 || lmul == 4)
			return 32'd0;
		max = vlmax_of(sew, lmul);
		if (max == 0)
			return 32'd0;
		return (avl < 32'(max)) ? avl : 32'(max);
	endfunction

	function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [2:0] sew, input logic [2:0] lmul);
		return {1'b0, 5'b00000, sew, lmul, rs1, 3'b111, rd, 7'b1010111};
	endfunction

	function automatic logic [31:0] enc_vsetivli(input logic [4:0] rd, input logic [4:0] uimm,
			input logic [2:0] sew, input logic [2:0] lmul);
		return {2'b11, 4'b0000, sew, lmul, uimm, 3'b111, rd, 7'b1010111};
	endfunction

	function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		return {1'b1, 6'd0, rs2, rs1, 3'b111, rd, 7'b1010111};
	endfunction

	// unit-stride vle/vse, unmasked
	function automatic logic [31:0] enc_mem(input logic store, input logic [4:0] vd,
			input logic [4:0] rs1, input logic [2:0] sew);
		logic [2:0] width;
		width = (sew == 3'd0) ? 3'b000 : (sew == 3'd1) ? 3'b101 : 3'b110;
		return {6'd0, 1'b1, 5'd0, rs1, width, vd, store ? 7'b0100111 : 7'b0000111};
	endfunction

	function automatic logic [7:0] pattern(input int a);
		return 8'(a) ^ (8'(a >> 8) * 8'd29) ^ 8'h5a; // upper address bits too
	endfunction

	task automatic fill_memory();
		for (int a = 0; a < MEM_BYTES; a++)
			mem[a] = pattern(a);
	endtask

	task automatic run_insn(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] rs2,
			output logic [31:0] rd, output logic wr, output int lat);
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1;
		pcpi_rs2   <= rs2;
		lat = 0;
		@(posedge clk);
		while (!pcpi_ready_o) begin
			lat++;
			@(posedge clk);
		end
		rd = pcpi_rd_o;
		wr = pcpi_wr_o;
		pcpi_valid <= 1'b0; // core lets go after ready
	endtask

	task automatic cfg_case(input string what, input logic [31:0] insn, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] exp_vl);
		logic [31:0] rd;
		logic        wr;
		int          lat;
		run_insn(insn, rs1, rs2, rd, wr, lat);
		check_value({what, " vl"}, exp_vl, rd);
		check_value({what, " wr"}, 32'd1, {31'd0, wr});
		check_value({what, " latency"}, 32'd1, 32'(lat));
	endtask

	task automatic mem_op(input logic store, input int base, input logic [2:0] sew,
			input logic [31:0] exp_vl, output int lat);
		logic [31:0] rd;
		logic        wr;
		string       what;
		what = store ? "store" : "load";
		exp_base  = base;
		exp_size  = 1 << sew;
		exp_store = store;
		req_seen  = 0;
		req_done  = 0;
		run_insn(enc_mem(store, 5'd8, 5'd6, sew), 32'(base), 32'd0, rd, wr, lat);
		check_value({what, " wr"}, 32'd0, {31'd0, wr});
		check_value({what, " requests"}, exp_vl, 32'(req_seen));
		check_value({what, " transfers"}, exp_vl, 32'(req_done));
	endtask

	task automatic probe_is_rvv(input string what, input logic [31:0] insn, input logic exp);
		@(posedge clk);
		pcpi_insn <= insn;
		@(posedge clk);
		check_value(what, {31'd0, exp}, {31'd0, pcpi_is_rvv_o});
	endtask

	task automatic round_trip(input int sew, input int lmul, input logic [31:0] avl);
		logic [31:0] vl;
		logic [7:0]  exp;
		int          lat;
		int          nbytes;
		start_test($sformatf("round trip e%0d lmul %0d", 8 << sew, 1 << lmul));
		vl = expected_vl(avl, sew, lmul);
		fill_memory();
		cfg_case("vsetvli", enc_vsetvli(5'd1, 5'd5, 3'(sew), 3'(lmul)), avl, 32'd0, vl);
		mem_op(1'b0, SRC_ADDR, 3'(sew), vl, lat);
		mem_op(1'b1, DST_ADDR, 3'(sew), vl, lat);
		nbytes = int'(vl) << sew;
		for (int a = 0; a < MEM_BYTES; a++) begin
			if (a >= DST_ADDR && a < DST_ADDR + nbytes)
				exp = pattern(SRC_ADDR + a - DST_ADDR);
			else
				exp = pattern(a); // untouched
			check_value($sformatf("mem[0x%0h]", a), {24'd0, exp}, {24'd0, mem[a]});
		end
		end_test();
	endtask

	// memory with a random done delay of 0 to 3 cycles
	initial begin : mem_model
		int          delay;
		int          wa;
		logic        done_now;
		logic        last_valid;
		logic [31:0] last_addr;
		logic [31:0] last_wdata;
		logic [3:0]  last_strb;
		logic [3:0]  elem_bytes;
		void'($urandom(SEED));
		mem_done   = 1'b0;
		mem_rdata  = 32'd0;
		last_valid = 1'b0;
		delay      = $urandom % 4;
		forever begin
			@(posedge clk);
			done_now = mem_done;
			mem_done <= 1'b0;
			if (mem_valid_o && last_valid) begin
				check_value("addr held", last_addr, mem_addr_o);
				check_value("strb held", {28'd0, last_strb}, {28'd0, mem_strb_o});
				check_value("wdata held", last_wdata, mem_wdata_o);
			end else if (mem_valid_o) begin
				req_seen++;
				elem_bytes = (exp_size == 1) ? 4'b0001 : (exp_size == 2) ? 4'b0011 : 4'b1111;
				check_value("addr", 32'(exp_base + req_done * exp_size), mem_addr_o);
				check_value("strb", {28'd0, elem_bytes << mem_addr_o[1:0]}, {28'd0, mem_strb_o});
				check_value("we", {31'd0, exp_store}, {31'd0, mem_we_o});
			end
			if (mem_valid_o && !done_now) begin
				check_value("first", {31'd0, req_done == 0}, {31'd0, mem_first_o});
				check_value("wait", 32'd1, {31'd0, pcpi_wait_o});
				check_value("mem_op", 32'd1, {31'd0, mem_op_o});
			end
			last_valid = mem_valid_o;
			last_addr  = mem_addr_o;
			last_strb  = mem_strb_o;
			last_wdata = mem_wdata_o;
			if (resetn && mem_valid_o && !done_now) begin
				if (delay == 0) begin
					wa = int'(mem_addr_o[9:2]) * 4;
					if (mem_we_o) begin
						for (int i = 0; i < 4; i++)
							if (mem_strb_o[i])
								mem[wa + i] = mem_wdata_o[i*8 +: 8];
					end else begin
						mem_rdata <= {mem[wa + 3], mem[wa + 2], mem[wa + 1], mem[wa]};
					end
					mem_done <= 1'b1;
					req_done++;
					delay = $urandom % 4;
				end else begin
					delay--;
				end
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin
		int lat;
		resetn     = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn  = 32'd0;
		pcpi_rs1   = 32'd0;
		pcpi_rs2   = 32'd0;
		fill_memory();
		repeat (10) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);

		start_test("reset");
		check_value("ready", 32'd0, {31'd0, pcpi_ready_o});
		check_value("wr", 32'd0, {31'd0, pcpi_wr_o});
		check_value("wait", 32'd0, {31'd0, pcpi_wait_o});
		check_value("mem_valid", 32'd0, {31'd0, mem_valid_o});
		check_value("mem_op", 32'd0, {31'd0, mem_op_o});
		check_value("mem_first", 32'd0, {31'd0, mem_first_o});
		check_value("vl", 32'd0, pcpi_rd_o);
		end_test();

		start_test("vsetvli");
		cfg_case("e32 avl 10", enc_vsetvli(5'd1, 5'd5, 3'd2, 3'd0), 32'd10, 32'd0,
			expected_vl(32'd10, 2, 0));
		cfg_case("e32 avl 3", enc_vsetvli(5'd1, 5'd5, 3'd2, 3'd0), 32'd3, 32'd0,
			expected_vl(32'd3, 2, 0));
		end_test();

		start_test("vsetivli and vsetvl");
		cfg_case("vsetivli e8", enc_vsetivli(5'd1, 5'd7, 3'd0, 3'd0), 32'd0, 32'd0,
			expected_vl(32'd7, 0, 0));
		cfg_case("vsetvl e16 m2", enc_vsetvl(5'd1, 5'd0, 5'd2), 32'd0, {26'd0, 3'd1, 3'd1},
			expected_vl(32'hffff_ffff, 1, 1));
		cfg_case("vsetvl e32 mf2", enc_vsetvl(5'd1, 5'd0, 5'd2), 32'd0, {26'd0, 3'd2, 3'd7},
			expected_vl(32'hffff_ffff, 2, 7));
		cfg_case("vsetvl e8 mf8", enc_vsetvl(5'd1, 5'd0, 5'd2), 32'd0, {26'd0, 3'd0, 3'd5},
			expected_vl(32'hffff_ffff, 0, 5));
		cfg_case("vsetvl e32 mf8", enc_vsetvl(5'd1, 5'd0, 5'd2), 32'd0, {26'd0, 3'd2, 3'd5},
			expected_vl(32'hffff_ffff, 2, 5));
		cfg_case("lmul code 4", enc_vsetvli(5'd1, 5'd5, 3'd0, 3'd4), 32'd5, 32'd0,
			expected_vl(32'd5, 0, 4));
		cfg_case("e64", enc_vsetvli(5'd1, 5'd5, 3'd3, 3'd0), 32'd5, 32'd0,
			expected_vl(32'd5, 3, 0));
		end_test();

		start_test("is_rvv");
		cfg_case("e8 setup", enc_vsetvli(5'd1, 5'd5, 3'd0, 3'd0), 32'd16, 32'd0,
			expected_vl(32'd16, 0, 0));
		probe_is_rvv("vsetvli", enc_vsetvli(5'd2, 5'd3, 3'd0, 3'd0), 1'b1);
		probe_is_rvv("vsetivli", enc_vsetivli(5'd2, 5'd4, 3'd1, 3'd0), 1'b1);
		probe_is_rvv("vsetvl", enc_vsetvl(5'd2, 5'd3, 5'd4), 1'b1);
		probe_is_rvv("vle8", enc_mem(1'b0, 5'd8, 5'd6, 3'd0), 1'b1);
		probe_is_rvv("vse8", enc_mem(1'b1, 5'd8, 5'd6, 3'd0), 1'b1);
		probe_is_rvv("add", 32'h00b5_0533, 1'b0); // add a0, a0, a1
		end_test();

		round_trip(0, 0, 32'd13);
		round_trip(1, 0, 32'd8);
		round_trip(2, 0, 32'd3);
		round_trip(0, 1, 32'd40); // two registers' worth
		round_trip(1, 1, 32'd11);
		round_trip(2, 1, 32'd7);

		start_test("empty vl");
		cfg_case("avl 0", enc_vsetvli(5'd1, 5'd5, 3'd0, 3'd0), 32'd0, 32'd0,
			expected_vl(32'd0, 0, 0));
		mem_op(1'b0, SRC_ADDR, 3'd0, 32'd0, lat);
		check_value("load latency", 32'd1, 32'(lat));
		mem_op(1'b1, DST_ADDR, 3'd0, 32'd0, lat);
		check_value("store latency", 32'd1, 32'(lat));
		end_test();

		@(posedge clk);
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end
endmodule

`default_nettype wire

// ==== verilog.f ====
design/rvv_pkg.sv
design/rvv_insn_decode.sv
design/rvv_cfg_unit.sv
design/rvv_ctrl_fsm.sv
design/rvv_elem_counter.sv
design/rvv_mem_lane.sv
design/rvv_vregs.sv
design/rvv_coproc.sv
test/tb_rvv_coproc.sv
